//--- bench/streamer_tb.sv
// Directed testbench for the streamer: loads, stores, casts and clear on one TCDM port
// Memory model preloaded from the tasks, results checked against reference casts here
`timescale 1ns/10ps
`include "streamer_cfg.svh"

module streamer_tb;

  // Words moved by all tests together, partial clear run included
  localparam int total_words    = 60;
  // Grant stalls, random X ready and FIFO refill per word, plus reset and setup
  localparam int timeout_cycles = total_words * 30 + 200;
  localparam int fifo_depth     = `STREAMER_FIFO_DEPTH;

  logic                          clk;
  logic                          rst_n;
  logic                          clear;
  streamer_pkg::streamer_ctrl_t  ctrl;
  streamer_pkg::streamer_flags_t flags;
  streamer_pkg::stream_t         x_stream;
  logic                          x_ready;
  streamer_pkg::stream_t         z_stream;
  logic                          z_ready;
  streamer_pkg::mem_req_t        mem_req;
  streamer_pkg::mem_rsp_t        mem_rsp;

  // Expected X words and Z words to send in the running test
  logic [31:0]         x_exp[$];
  streamer_pkg::word_u z_words[$];
  int                  x_seen;
  int                  z_sent;

  int err_cnt   = 0;
  int err_base  = 0;
  int test_cnt  = 0;
  int bad_tests = 0;
  int cycle_cnt = 0;
  int seed      = 32'h8e2b;

  streamer_top dut_i (
    .clk_i      ( clk      ),
    .rst_n_i    ( rst_n    ),
    .clear_i    ( clear    ),
    .ctrl_i     ( ctrl     ),
    .flags_o    ( flags    ),
    .x_stream_o ( x_stream ),
    .x_ready_i  ( x_ready  ),
    .z_stream_i ( z_stream ),
    .z_ready_o  ( z_ready  ),
    .mem_req_o  ( mem_req  ),
    .mem_rsp_i  ( mem_rsp  )
  );

  tcdm_mem_model mem_i (
    .clk_i     ( clk     ),
    .rst_n_i   ( rst_n   ),
    .mem_req_i ( mem_req ),
    .mem_rsp_o ( mem_rsp )
  );

  always #5 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: a transfer never finished within %0d cycles", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  // Mixes every address bit into the stored value
  function automatic logic [31:0] fill_word(input logic [31:0] addr, input logic [7:0] salt);
    return (addr * 32'h9e37_79b1) ^ {salt, addr[31:8]} ^ 32'h5a5a_0f0f;
  endfunction

  // Memory FP8 pair in the low half widened to two FP16 lanes
  function automatic logic [31:0] widen_fp8_pair(input logic [31:0] w);
    return {w[15:8], 8'h00, w[7:0], 8'h00};
  endfunction

  // FP16 to E5M2 by dropping the low byte, nearest even
  function automatic logic [7:0] round_fp16_to_fp8(input logic [15:0] h);
    logic [7:0] keep;
    logic [7:0] rest;
    keep = h[15:8];
    rest = h[7:0];
    if (h[14:10] == 5'h1f && h[9:0] != 10'h0) begin
      return 8'h7e;
    end
    // Above half, or exactly half with an odd kept part
    if (rest > 8'h80 || (rest == 8'h80 && keep[0])) begin
      return keep + 8'h01;
    end
    return keep;
  endfunction

  function automatic streamer_pkg::chan_ctrl_t make_ctrl(input logic [31:0] base,
      input logic [15:0] len, input logic [15:0] stride, input logic cast);
    streamer_pkg::chan_ctrl_t c;
    c.start     = 1'b1;
    c.base_addr = base;
    c.len       = len;
    c.stride    = stride;
    c.cast_en   = cast;
    return c;
  endfunction

  task automatic preload(input logic [31:0] base, input int len, input int stride,
      input logic [7:0] salt);
    logic [31:0] a;
    for (int i = 0; i < len; i++) begin
      a = base + i * stride;
      mem_i.words[a[11:2]] = fill_word(a, salt);
    end
  endtask

  // Preload a load region and queue what X should deliver
  task automatic setup_load(input logic [31:0] base, input int len, input int stride,
      input logic cast, input logic [7:0] salt);
    logic [31:0] a;
    preload(base, len, stride, salt);
    for (int i = 0; i < len; i++) begin
      a = base + i * stride;
      x_exp.push_back(cast ? widen_fp8_pair(fill_word(a, salt)) : fill_word(a, salt));
    end
  endtask

  task automatic start_transfer(input streamer_pkg::chan_ctrl_t xc,
      input streamer_pkg::chan_ctrl_t zc);
    ctrl.x_ctrl = xc;
    ctrl.z_ctrl = zc;
    @(posedge clk);
    #1;
    ctrl = '0;
  endtask

  // Drives X ready and Z words, checks X data, credit and done timing
  task automatic move_words(input bit rand_ready, input int stop_after);
    logic [31:0] rnd;
    int          cyc;
    int          credit;
    int          last_pop;
    int          last_wr;
    bit          x_end;
    bit          z_end;
    cyc      = 0;
    credit   = 0;
    last_pop = -1;
    last_wr  = -1;
    x_seen   = 0;
    z_sent   = 0;
    x_end    = (x_exp.size() == 0);
    z_end    = (z_words.size() == 0);
    while (!(x_end && z_end) && !(stop_after > 0 && cyc >= stop_after)) begin
      rnd            = $random(seed);
      x_ready        = rand_ready ? rnd[0] : 1'b1;
      z_stream.valid = (z_sent < z_words.size());
      if (z_sent < z_words.size()) begin
        z_stream.data = z_words[z_sent];
      end
      @(negedge clk);
      // A read may only go out while the FIFO has room for its answer
      if (mem_req.req && mem_req.wen) begin
        assert (credit < fifo_depth) else begin
          $display("Read issued at %0t with %0d words held or in flight", $time, credit);
          err_cnt++;
        end
        if (mem_rsp.gnt) begin
          credit++;
        end
      end
      if (mem_req.req && !mem_req.wen && mem_rsp.gnt) begin
        last_wr = cyc;
      end
      if (x_stream.valid && x_ready) begin
        assert (x_seen < x_exp.size()) else begin
          $display("Mismatch at %0t: X stream gave extra word %0d", $time, x_seen);
          err_cnt++;
        end
        if (x_seen < x_exp.size()) begin
          assert (x_stream.data == x_exp[x_seen]) else begin
            $display("Mismatch at %0t: X word %0d is %h, expected %h", $time, x_seen,
                     x_stream.data, x_exp[x_seen]);
            err_cnt++;
          end
        end
        x_seen++;
        credit--;
        last_pop = cyc;
      end
      if (z_stream.valid && z_ready) begin
        z_sent++;
      end
      if (flags.x_flags.done) begin
        assert (cyc == last_pop + 1) else begin
          $display("X done came %0d cycles after the last X word", cyc - last_pop);
          err_cnt++;
        end
        x_end = 1'b1;
      end
      if (flags.z_flags.done) begin
        assert (cyc == last_wr + 1) else begin
          $display("Z done came %0d cycles after the last write grant", cyc - last_wr);
          err_cnt++;
        end
        z_end = 1'b1;
      end
      @(posedge clk);
      #1;
      cyc++;
    end
    x_ready        = 1'b0;
    z_stream.valid = 1'b0;
  endtask

  task automatic check_counts();
    assert (x_seen == x_exp.size()) else begin
      $display("Mismatch at %0t: X stream gave %0d words, expected %0d", $time, x_seen,
               x_exp.size());
      err_cnt++;
    end
    assert (z_sent == z_words.size()) else begin
      $display("Mismatch at %0t: sink took %0d Z words, expected %0d", $time, z_sent,
               z_words.size());
      err_cnt++;
    end
  endtask

  // Store region against the Z words, cast or plain
  task automatic check_store(input logic [31:0] base, input int stride, input logic cast,
      input logic [7:0] salt);
    logic [31:0]         a;
    logic [31:0]         old;
    logic [31:0]         exp;
    streamer_pkg::word_u z;
    for (int i = 0; i < z_words.size(); i++) begin
      a   = base + i * stride;
      old = fill_word(a, salt);
      z   = z_words[i];
      exp = cast ? {old[31:16], round_fp16_to_fp8(z.h[1]), round_fp16_to_fp8(z.h[0])} : z;
      assert (mem_i.words[a[11:2]] == exp) else begin
        $display("Mismatch at %0t: memory at %h is %h, expected %h", $time, a,
                 mem_i.words[a[11:2]], exp);
        err_cnt++;
      end
    end
  endtask

  task automatic check_idle(input string what);
    @(negedge clk);
    assert (!mem_req.req && !x_stream.valid && !z_ready && !flags.x_flags.busy &&
            !flags.z_flags.busy && !flags.x_flags.done && !flags.z_flags.done) else begin
      $display("Channels not idle %s: req %b valid %b ready %b busy %b%b done %b%b", what,
               mem_req.req, x_stream.valid, z_ready, flags.x_flags.busy,
               flags.z_flags.busy, flags.x_flags.done, flags.z_flags.done);
      err_cnt++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic begin_test();
    x_exp.delete();
    z_words.delete();
    err_base = err_cnt;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == err_base) begin
      $display("Test %s: ok", name);
    end else begin
      bad_tests++;
      $display("Test %s: %0d errors", name, err_cnt - err_base);
    end
  endtask

  task automatic plain_load_test();
    begin_test();
    check_idle("after reset");
    setup_load(32'h100, 8, 4, 1'b0, 8'h11);
    start_transfer(make_ctrl(32'h100, 8, 4, 1'b0), '0);
    move_words(1'b0, 0);
    check_counts();
    end_test("plain load");
  endtask

  task automatic cast_load_test();
    begin_test();
    setup_load(32'h200, 8, 8, 1'b1, 8'h22);
    start_transfer(make_ctrl(32'h200, 8, 8, 1'b1), '0);
    move_words(1'b1, 0);
    check_counts();
    end_test("cast load");
  endtask

  task automatic cast_store_test();
    begin_test();
    preload(32'h300, 8, 4, 8'h33);
    // Round up and ties, round down, overflow, NaN, infinity, tiny, negative
    z_words.push_back(32'h3c81_3c80);
    z_words.push_back(32'h3d80_3c7f);
    z_words.push_back(32'h7bff_7b80);
    z_words.push_back(32'h7e01_fc01);
    z_words.push_back(32'h7c00_bc90);
    z_words.push_back(32'h0080_0180);
    z_words.push_back(32'hfbff_4000);
    z_words.push_back(32'h7fff_0001);
    start_transfer('0, make_ctrl(32'h300, 8, 4, 1'b1));
    move_words(1'b0, 0);
    check_counts();
    check_store(32'h300, 4, 1'b1, 8'h33);
    end_test("cast store");
  endtask

  task automatic plain_store_test();
    begin_test();
    preload(32'h600, 6, 12, 8'h44);
    for (int i = 0; i < 6; i++) begin
      z_words.push_back(fill_word(32'h1000 + i, 8'h55));
    end
    setup_load(32'h400, 6, 4, 1'b0, 8'h66);
    start_transfer(make_ctrl(32'h400, 6, 4, 1'b0), make_ctrl(32'h600, 6, 12, 1'b0));
    move_words(1'b0, 0);
    check_counts();
    check_store(32'h600, 12, 1'b0, 8'h44);
    end_test("plain store with load");
  endtask

  task automatic clear_test();
    begin_test();
    setup_load(32'h800, 8, 4, 1'b0, 8'h77);
    preload(32'h900, 8, 4, 8'h78);
    for (int i = 0; i < 8; i++) begin
      z_words.push_back(fill_word(32'h2000 + i, 8'h79));
    end
    start_transfer(make_ctrl(32'h800, 8, 4, 1'b0), make_ctrl(32'h900, 8, 4, 1'b0));
    // Stop both channels part way through
    move_words(1'b0, 6);
    // Both channels still have words left here
    assert (flags.x_flags.busy && flags.z_flags.busy) else begin
      $display("Channels not busy before clear: busy %b%b", flags.x_flags.busy,
               flags.z_flags.busy);
      err_cnt++;
    end
    clear = 1'b1;
    @(posedge clk);
    #1;
    clear = 1'b0;
    check_idle("after clear");
    x_exp.delete();
    z_words.delete();
    setup_load(32'ha00, 4, 4, 1'b1, 8'h7a);
    preload(32'hb00, 4, 8, 8'h7b);
    for (int i = 0; i < 4; i++) begin
      z_words.push_back(fill_word(32'h3000 + i, 8'h7c));
    end
    start_transfer(make_ctrl(32'ha00, 4, 4, 1'b1), make_ctrl(32'hb00, 4, 8, 1'b0));
    move_words(1'b0, 0);
    check_counts();
    check_store(32'hb00, 8, 1'b0, 8'h7b);
    end_test("clear");
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    clear    = 1'b0;
    ctrl     = '0;
    x_ready  = 1'b0;
    z_stream = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    plain_load_test();
    cast_load_test();
    cast_store_test();
    plain_store_test();
    clear_test();
    $display("Tests run %0d, tests with errors %0d, errors %0d", test_cnt, bad_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- bench/tcdm_mem_model.sv
// Behavioral TCDM word memory for the streamer testbench
// Grants stall at random and every granted access answers one cycle later
`timescale 1ns/10ps

module tcdm_mem_model (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  streamer_pkg::mem_req_t mem_req_i,
  output streamer_pkg::mem_rsp_t mem_rsp_o
);

  localparam int unsigned n_words = 1024;

  // Word array, also preloaded and read back by the testbench tasks
  logic [31:0] words [n_words];

  int          seed = 32'h8e2b;
  logic        stall_q;
  logic        r_valid_q;
  logic [31:0] r_data_q;
  logic [9:0]  idx;

  // Word index from the byte address
  assign idx = mem_req_i.add[11:2];

  assign mem_rsp_o.gnt     = mem_req_i.req & ~stall_q;
  assign mem_rsp_o.r_valid = r_valid_q;
  assign mem_rsp_o.r_data  = r_data_q;

  initial begin
    for (int i = 0; i < n_words; i++) begin
      words[i] = '0;
    end
  end

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stall_q   <= 1'b0;
      r_valid_q <= 1'b0;
      r_data_q  <= '0;
    end else begin
      // About one cycle in four withholds the grant
      stall_q   <= (($random(seed) & 3) == 0);
      // Writes answer too, the mux drops those
      r_valid_q <= mem_rsp_o.gnt;
      if (mem_rsp_o.gnt && mem_req_i.wen) begin
        r_data_q <= words[idx];
      end
    end
  end

  // Byte-enabled write on grant
  always @(posedge clk_i) begin
    if (mem_rsp_o.gnt && !mem_req_i.wen) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_req_i.be[b]) begin
          words[idx][8*b +: 8] = mem_req_i.data.b[b];
        end
      end
    end
  end

endmodule

//--- filelist.f
+incdir+rtl
rtl/streamer_pkg.sv
rtl/stream_source.sv
rtl/stream_sink.sv
rtl/ldst_mux.sv
rtl/streamer_top.sv
bench/tcdm_mem_model.sv
bench/streamer_tb.sv

//--- rtl/ldst_mux.sv
// Load/store arbiter in front of the single TCDM port
// Alternates on contention and steers read responses back to the load side
`timescale 1ns/10ps

module ldst_mux (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   clear_i,
  input  streamer_pkg::mem_req_t load_req_i,
  input  streamer_pkg::mem_req_t store_req_i,
  output streamer_pkg::mem_rsp_t load_rsp_o,
  output streamer_pkg::mem_rsp_t store_rsp_o,
  output streamer_pkg::mem_req_t mem_req_o,
  input  streamer_pkg::mem_rsp_t mem_rsp_i
);

  // Store gets the next contested slot when set
  logic prio_store_q;
  // Ungranted request pending, keep the same owner on the port
  logic hold_q;
  logic hold_store_q;
  // Next r_valid belongs to a load read
  logic rsp_load_q;

  logic sel_store;
  logic fire;

  always_comb begin
    if (hold_q) begin
      sel_store = hold_store_q;
    end else if (load_req_i.req && store_req_i.req) begin
      sel_store = prio_store_q;
    end else begin
      sel_store = store_req_i.req;
    end
  end

  assign mem_req_o = sel_store ? store_req_i : load_req_i;
  assign fire      = mem_req_o.req & mem_rsp_i.gnt;

  // Grant only to the selected side
  assign load_rsp_o.gnt      = fire & ~sel_store;
  assign load_rsp_o.r_valid  = rsp_load_q & mem_rsp_i.r_valid;
  assign load_rsp_o.r_data   = mem_rsp_i.r_data;
  assign store_rsp_o.gnt     = fire & sel_store;
  // Write acknowledges are dropped here
  assign store_rsp_o.r_valid = 1'b0;
  assign store_rsp_o.r_data  = mem_rsp_i.r_data;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_store_q <= 1'b0;
      hold_q       <= 1'b0;
      hold_store_q <= 1'b0;
      rsp_load_q   <= 1'b0;
    end else if (clear_i) begin
      prio_store_q <= 1'b0;
      hold_q       <= 1'b0;
      hold_store_q <= 1'b0;
      rsp_load_q   <= 1'b0;
    end else begin
      if (fire) begin
        prio_store_q <= ~sel_store;
      end
      hold_q       <= mem_req_o.req & ~mem_rsp_i.gnt;
      hold_store_q <= sel_store;
      rsp_load_q   <= fire & ~sel_store & load_req_i.wen;
    end
  end

endmodule

//--- rtl/stream_sink.sv
// Store channel: Z stream words rounded to FP8 if asked, written back with a stride
// One write register sits between the stream and the memory port
`timescale 1ns/10ps
`include "streamer_cfg.svh"

module stream_sink (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      clear_i,
  input  streamer_pkg::chan_ctrl_t  ctrl_i,
  output streamer_pkg::chan_flags_t flags_o,
  input  streamer_pkg::stream_t     z_stream_i,
  output logic                      z_ready_o,
  output streamer_pkg::mem_req_t    mem_req_o,
  input  streamer_pkg::mem_rsp_t    mem_rsp_i
);

  localparam int unsigned dw = `STREAMER_DW;
  localparam int unsigned aw = `STREAMER_AW;
  // FP8 pair lives in byte lanes 0 and 1
  localparam logic [dw/8-1:0] be_cast = 'b11;

  // FP16 to E5M2, round to nearest even on the dropped byte
  function automatic logic [7:0] fp16_to_fp8(input logic [15:0] h);
    logic round_up;
    logic is_nan;
    round_up = h[7] & ((|h[6:0]) | h[8]);
    is_nan   = (h[14:10] == 5'h1f) & (h[9:0] != '0);
    // Carry may reach the exponent, largest finite values go to infinity
    return is_nan ? 8'h7e : h[15:8] + {7'b0, round_up};
  endfunction

  logic                      busy_q;
  logic                      done_q;
  logic                      cast_q;
  logic [aw-1:0]             addr_q;
  logic [15:0]               stride_q;
  logic [`STREAMER_LENW-1:0] accept_left_q;
  logic [`STREAMER_LENW-1:0] write_left_q;

  // Write register
  logic                      wr_valid_q;
  logic [aw-1:0]             wr_add_q;
  streamer_pkg::word_u       wr_data_q;
  logic [dw/8-1:0]           wr_be_q;

  logic                      wr_gnt;
  logic                      accept;
  streamer_pkg::word_u       cast_data;

  assign wr_gnt    = wr_valid_q & mem_rsp_i.gnt;
  // Register free now or emptied by this cycle's grant
  assign z_ready_o = busy_q & (accept_left_q != '0) & (~wr_valid_q | wr_gnt);
  assign accept    = z_stream_i.valid & z_ready_o;

  always_comb begin
    cast_data = z_stream_i.data;
    if (cast_q) begin
      // Upper bytes masked off by be
      cast_data = '0;
      for (int i = 0; i < dw / 16; i++) begin
        cast_data.b[i] = fp16_to_fp8(z_stream_i.data.h[i]);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q        <= 1'b0;
      done_q        <= 1'b0;
      cast_q        <= 1'b0;
      addr_q        <= '0;
      stride_q      <= '0;
      accept_left_q <= '0;
      write_left_q  <= '0;
      wr_valid_q    <= 1'b0;
    end else if (clear_i) begin
      busy_q        <= 1'b0;
      done_q        <= 1'b0;
      cast_q        <= 1'b0;
      addr_q        <= '0;
      stride_q      <= '0;
      accept_left_q <= '0;
      write_left_q  <= '0;
      wr_valid_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (ctrl_i.start && !busy_q) begin
        busy_q        <= (ctrl_i.len != '0);
        done_q        <= (ctrl_i.len == '0);
        cast_q        <= ctrl_i.cast_en;
        addr_q        <= ctrl_i.base_addr;
        stride_q      <= ctrl_i.stride;
        accept_left_q <= ctrl_i.len;
        write_left_q  <= ctrl_i.len;
      end else begin
        if (accept) begin
          addr_q        <= addr_q + aw'(stride_q);
          accept_left_q <= accept_left_q - 1'b1;
        end
        if (wr_gnt) begin
          write_left_q <= write_left_q - 1'b1;
          // Last write granted
          if (write_left_q == 1) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
      // New word wins over the draining one
      if (accept) begin
        wr_valid_q <= 1'b1;
      end else if (wr_gnt) begin
        wr_valid_q <= 1'b0;
      end
    end
  end

  // Write payload, loaded one cycle before the request shows
  always_ff @(posedge clk_i) begin
    if (accept) begin
      wr_add_q  <= addr_q;
      wr_data_q <= cast_data;
      wr_be_q   <= cast_q ? be_cast : '1;
    end
  end

  assign mem_req_o.req  = wr_valid_q;
  assign mem_req_o.wen  = 1'b0;
  assign mem_req_o.add  = wr_add_q;
  assign mem_req_o.data = wr_data_q;
  assign mem_req_o.be   = wr_be_q;

  assign flags_o.busy = busy_q;
  assign flags_o.done = done_q;

endmodule

//--- rtl/stream_source.sv
// Load channel: strided TCDM reads into a credit-limited FIFO, out as the X stream
// FP8 memory words are widened to FP16 lanes on the FIFO output when cast is on
`timescale 1ns/10ps
`include "streamer_cfg.svh"

module stream_source (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      clear_i,
  input  streamer_pkg::chan_ctrl_t  ctrl_i,
  output streamer_pkg::chan_flags_t flags_o,
  output streamer_pkg::mem_req_t    mem_req_o,
  input  streamer_pkg::mem_rsp_t    mem_rsp_i,
  output streamer_pkg::stream_t     x_stream_o,
  input  logic                      x_ready_i
);

  localparam int unsigned dw    = `STREAMER_DW;
  localparam int unsigned aw    = `STREAMER_AW;
  localparam int unsigned depth = `STREAMER_FIFO_DEPTH;
  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);

  // Channel control state
  logic                      busy_q;
  logic                      done_q;
  logic                      cast_q;
  logic [aw-1:0]             addr_q;
  logic [15:0]               stride_q;
  logic [`STREAMER_LENW-1:0] issue_left_q;
  logic [`STREAMER_LENW-1:0] pop_left_q;

  // Response FIFO and credits
  streamer_pkg::word_u fifo_q [depth];
  logic [ptr_w-1:0]    wr_ptr_q;
  logic [ptr_w-1:0]    rd_ptr_q;
  logic [cnt_w-1:0]    fifo_cnt_q;
  // Words in flight plus words held in the FIFO
  logic [cnt_w-1:0]    credit_q;

  logic                issue_fire;
  logic                push;
  logic                pop;
  streamer_pkg::word_u head;
  streamer_pkg::word_u x_data;

  assign issue_fire = mem_req_o.req & mem_rsp_i.gnt;
  // Only load read responses reach this port
  assign push       = mem_rsp_i.r_valid;
  assign pop        = x_stream_o.valid & x_ready_i;

  // Read only while a FIFO slot is guaranteed for the answer
  assign mem_req_o.req  = busy_q & (issue_left_q != '0) & (credit_q < cnt_w'(depth));
  assign mem_req_o.wen  = 1'b1;
  assign mem_req_o.add  = addr_q;
  assign mem_req_o.data = '0;
  assign mem_req_o.be   = '1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q       <= 1'b0;
      done_q       <= 1'b0;
      cast_q       <= 1'b0;
      addr_q       <= '0;
      stride_q     <= '0;
      issue_left_q <= '0;
      pop_left_q   <= '0;
    end else if (clear_i) begin
      busy_q       <= 1'b0;
      done_q       <= 1'b0;
      cast_q       <= 1'b0;
      addr_q       <= '0;
      stride_q     <= '0;
      issue_left_q <= '0;
      pop_left_q   <= '0;
    end else begin
      done_q <= 1'b0;
      if (ctrl_i.start && !busy_q) begin
        // Empty transfer finishes at once
        busy_q       <= (ctrl_i.len != '0);
        done_q       <= (ctrl_i.len == '0);
        cast_q       <= ctrl_i.cast_en;
        addr_q       <= ctrl_i.base_addr;
        stride_q     <= ctrl_i.stride;
        issue_left_q <= ctrl_i.len;
        pop_left_q   <= ctrl_i.len;
      end else begin
        if (issue_fire) begin
          addr_q       <= addr_q + aw'(stride_q);
          issue_left_q <= issue_left_q - 1'b1;
        end
        if (pop) begin
          pop_left_q <= pop_left_q - 1'b1;
          // Last word accepted on X
          if (pop_left_q == 1) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
      credit_q   <= '0;
    end else if (clear_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
      credit_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      fifo_cnt_q <= fifo_cnt_q + cnt_w'(push) - cnt_w'(pop);
      // Credit taken at grant, returned when X takes the word
      credit_q   <= credit_q + cnt_w'(issue_fire) - cnt_w'(pop);
    end
  end

  // FIFO storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= mem_rsp_i.r_data;
    end
  end

  // Cast-in, FP8 lane i becomes the top byte of FP16 lane i
  always_comb begin
    head   = fifo_q[rd_ptr_q];
    x_data = head;
    if (cast_q) begin
      for (int i = 0; i < dw / 16; i++) begin
        x_data.h[i] = {head.b[i], 8'h00};
      end
    end
  end

  assign x_stream_o.valid = (fifo_cnt_q != '0);
  assign x_stream_o.data  = x_data;

  assign flags_o.busy = busy_q;
  assign flags_o.done = done_q;

endmodule

//--- rtl/streamer_cfg.svh
// Width and depth settings of the streamer data mover
// Included by the package and by the channels that size counters and FIFOs
`ifndef STREAMER_CFG_SVH
`define STREAMER_CFG_SVH

// Memory and stream word width in bits
`define STREAMER_DW 32

// Byte address width
`define STREAMER_AW 32

// Width of the word count of a transfer
`define STREAMER_LENW 16

// Load response FIFO depth, a power of two (2, 4 or 8)
`define STREAMER_FIFO_DEPTH 4

`endif

//--- rtl/streamer_pkg.sv
// Shared types of the streamer: control, flags, memory port and stream structs
// Referenced with scoped names by every streamer module
`include "streamer_cfg.svh"

package streamer_pkg;

  // One word seen as FP16 lanes or as FP8 lanes
  typedef union packed {
    logic [`STREAMER_DW/16-1:0][15:0] h;
    logic [`STREAMER_DW/8-1:0][7:0]   b;
  } word_u;

  // Per channel transfer setup
  typedef struct packed {
    logic                      start;
    logic [`STREAMER_AW-1:0]   base_addr;
    logic [`STREAMER_LENW-1:0] len;
    logic [15:0]               stride;
    logic                      cast_en;
  } chan_ctrl_t;

  typedef struct packed {
    chan_ctrl_t x_ctrl;
    chan_ctrl_t z_ctrl;
  } streamer_ctrl_t;

  typedef struct packed {
    logic busy;
    logic done;
  } chan_flags_t;

  typedef struct packed {
    chan_flags_t x_flags;
    chan_flags_t z_flags;
  } streamer_flags_t;

  // TCDM request, wen high means read
  typedef struct packed {
    logic                      req;
    logic                      wen;
    logic [`STREAMER_AW-1:0]   add;
    word_u                     data;
    logic [`STREAMER_DW/8-1:0] be;
  } mem_req_t;

  typedef struct packed {
    logic                    gnt;
    logic                    r_valid;
    logic [`STREAMER_DW-1:0] r_data;
  } mem_rsp_t;

  // Ready travels back on its own wire
  typedef struct packed {
    logic  valid;
    word_u data;
  } stream_t;

endpackage

//--- rtl/streamer_top.sv
// Streamer top: load source and store sink sharing one TCDM port
// Control and flags per channel, X stream out and Z stream in
`timescale 1ns/10ps

module streamer_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          clear_i,
  input  streamer_pkg::streamer_ctrl_t  ctrl_i,
  output streamer_pkg::streamer_flags_t flags_o,
  output streamer_pkg::stream_t         x_stream_o,
  input  logic                          x_ready_i,
  input  streamer_pkg::stream_t         z_stream_i,
  output logic                          z_ready_o,
  output streamer_pkg::mem_req_t        mem_req_o,
  input  streamer_pkg::mem_rsp_t        mem_rsp_i
);

  // Channel side of the multiplexer
  streamer_pkg::mem_req_t load_req;
  streamer_pkg::mem_rsp_t load_rsp;
  streamer_pkg::mem_req_t store_req;
  streamer_pkg::mem_rsp_t store_rsp;

  stream_source i_source (
    .clk_i      ( clk_i          ),
    .rst_n_i    ( rst_n_i        ),
    .clear_i    ( clear_i        ),
    .ctrl_i     ( ctrl_i.x_ctrl  ),
    .flags_o    ( flags_o.x_flags ),
    .mem_req_o  ( load_req       ),
    .mem_rsp_i  ( load_rsp       ),
    .x_stream_o ( x_stream_o     ),
    .x_ready_i  ( x_ready_i      )
  );

  stream_sink i_sink (
    .clk_i      ( clk_i           ),
    .rst_n_i    ( rst_n_i         ),
    .clear_i    ( clear_i         ),
    .ctrl_i     ( ctrl_i.z_ctrl   ),
    .flags_o    ( flags_o.z_flags ),
    .z_stream_i ( z_stream_i      ),
    .z_ready_o  ( z_ready_o       ),
    .mem_req_o  ( store_req       ),
    .mem_rsp_i  ( store_rsp       )
  );

  ldst_mux i_ldst_mux (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .clear_i     ( clear_i   ),
    .load_req_i  ( load_req  ),
    .store_req_i ( store_req ),
    .load_rsp_o  ( load_rsp  ),
    .store_rsp_o ( store_rsp ),
    .mem_req_o   ( mem_req_o ),
    .mem_rsp_i   ( mem_rsp_i )
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the streamer testbench with Verilator, run it and check the log
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module streamer_tb -o streamer_sim
if [ $? -ne 0 ]; then
  echo "Verilator build returned an error"
  exit 1
fi

./obj_dir/streamer_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation passed" "$log"; then
  exit 0
else
  echo "Pass message not found in $log"
  exit 1
fi
